//--- source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	// datapath widths.
	localparam int data_w = 32;
	localparam int reg_addr_w = 5;
	localparam int imm_w = 16;
	localparam int dmem_addr_w = 8;

	// instruction opcodes.
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or  = 3'd3,
		op_xor = 3'd4,
		op_li  = 3'd5,
		op_ld  = 3'd6,
		op_st  = 3'd7
	} opcode_e;

	// where the REG2 write value comes from.
	typedef enum logic [1:0] {
		wrreg_alu = 2'd0,
		wrreg_imm = 2'd1,
		wrreg_mem = 2'd2
	} wr_src_e;

	// operand source picked by the forwarding mux.
	typedef enum logic [2:0] {
		fwd_orig     = 3'd0,
		fwd_reg4     = 3'd1,
		fwd_reg3     = 3'd2,
		fwd_reg2_imm = 3'd3,
		fwd_reg2_alu = 3'd4
	} fwd_sel_e;

endpackage

`default_nettype wire

//--- source/fwd_src_if.sv
`timescale 1ns/10ps
`default_nettype none

interface fwd_src_if;
	// REG2 candidate, not usable while a load.
	logic                                reg2_do_dm_read;
	logic                                reg2_do_reg_write;
	pipe_pkg::wr_src_e                   reg2_select_write_reg;
	logic [pipe_pkg::reg_addr_w-1:0]     reg2_write_reg_addr;
	logic [pipe_pkg::data_w-1:0]         reg2_imm_extend;
	logic [pipe_pkg::data_w-1:0]         alu_result;

	// REG3 candidate.
	logic                                reg3_do_reg_write;
	logic [pipe_pkg::reg_addr_w-1:0]     reg3_write_reg_addr;
	logic [pipe_pkg::data_w-1:0]         write_reg_data;

	// REG4 candidate, same cycle as the register file write.
	logic                                reg4_do_reg_write;
	logic [pipe_pkg::reg_addr_w-1:0]     reg4_write_reg_addr;
	logic [pipe_pkg::data_w-1:0]         reg4_write_reg_data;

	modport pipe (
		output reg2_do_dm_read, reg2_do_reg_write, reg2_select_write_reg,
		output reg2_write_reg_addr, reg2_imm_extend, alu_result,
		output reg3_do_reg_write, reg3_write_reg_addr, write_reg_data,
		output reg4_do_reg_write, reg4_write_reg_addr, reg4_write_reg_data
	);

	modport fwd (
		input reg2_do_dm_read, reg2_do_reg_write, reg2_select_write_reg,
		input reg2_write_reg_addr, reg2_imm_extend, alu_result,
		input reg3_do_reg_write, reg3_write_reg_addr, write_reg_data,
		input reg4_do_reg_write, reg4_write_reg_addr, reg4_write_reg_data
	);
endinterface

`default_nettype wire

//--- source/operand_forward.sv
`timescale 1ns/10ps
`default_nettype none

module operand_forward (
	input  wire [pipe_pkg::reg_addr_w-1:0] reg_rx_addr,
	input  wire [pipe_pkg::data_w-1:0]     reg_rx_data,
	fwd_src_if.fwd                         src,
	output logic [pipe_pkg::data_w-1:0]    f_reg_rx_data
);
	pipe_pkg::fwd_sel_e sel;
	logic               hit_reg2;
	logic               hit_reg3;
	logic               hit_reg4;

	// a load in REG2 has no data yet.
	assign hit_reg2 = src.reg2_do_reg_write
		&& (reg_rx_addr == src.reg2_write_reg_addr)
		&& !src.reg2_do_dm_read;

	assign hit_reg3 = src.reg3_do_reg_write
		&& (reg_rx_addr == src.reg3_write_reg_addr);

	assign hit_reg4 = src.reg4_do_reg_write
		&& (reg_rx_addr == src.reg4_write_reg_addr);

	// youngest producer wins.
	always_comb begin
		if (hit_reg2) begin
			if (src.reg2_select_write_reg == pipe_pkg::wrreg_imm) begin
				sel = pipe_pkg::fwd_reg2_imm;
			end else begin
				sel = pipe_pkg::fwd_reg2_alu;
			end
		end else if (hit_reg3) begin
			sel = pipe_pkg::fwd_reg3;
		end else if (hit_reg4) begin
			sel = pipe_pkg::fwd_reg4;
		end else begin
			sel = pipe_pkg::fwd_orig;
		end
	end

	always_comb begin
		case (sel)
			pipe_pkg::fwd_reg4: begin
				f_reg_rx_data = src.reg4_write_reg_data;
			end
			pipe_pkg::fwd_reg3: begin
				f_reg_rx_data = src.write_reg_data;
			end
			pipe_pkg::fwd_reg2_imm: begin
				f_reg_rx_data = src.reg2_imm_extend;
			end
			pipe_pkg::fwd_reg2_alu: begin
				f_reg_rx_data = src.alu_result;
			end
			default: begin
				f_reg_rx_data = reg_rx_data;
			end
		endcase
	end
endmodule

`default_nettype wire

//--- source/forward_unit.sv
`timescale 1ns/10ps
`default_nettype none

module forward_unit (
	input  wire [pipe_pkg::reg_addr_w-1:0] reg_ra_addr,
	input  wire [pipe_pkg::reg_addr_w-1:0] reg_rb_addr,
	input  wire [pipe_pkg::reg_addr_w-1:0] reg_rt_addr,
	input  wire [pipe_pkg::data_w-1:0]     reg_ra_data,
	input  wire [pipe_pkg::data_w-1:0]     reg_rb_data,
	input  wire [pipe_pkg::data_w-1:0]     reg_rt_data,
	fwd_src_if.fwd                         src,
	output logic [pipe_pkg::data_w-1:0]    f_reg_ra_data,
	output logic [pipe_pkg::data_w-1:0]    f_reg_rb_data,
	output logic [pipe_pkg::data_w-1:0]    f_reg_rt_data,
	output logic                           do_hazard
);
	logic addr_match;

	operand_forward fwd_ra (
		.reg_rx_addr   (reg_ra_addr),
		.reg_rx_data   (reg_ra_data),
		.src           (src),
		.f_reg_rx_data (f_reg_ra_data)
	);

	operand_forward fwd_rb (
		.reg_rx_addr   (reg_rb_addr),
		.reg_rx_data   (reg_rb_data),
		.src           (src),
		.f_reg_rx_data (f_reg_rb_data)
	);

	operand_forward fwd_rt (
		.reg_rx_addr   (reg_rt_addr),
		.reg_rx_data   (reg_rt_data),
		.src           (src),
		.f_reg_rx_data (f_reg_rt_data)
	);

	// all three fields checked, used or not.
	assign addr_match = (reg_ra_addr == src.reg2_write_reg_addr)
		|| (reg_rb_addr == src.reg2_write_reg_addr)
		|| (reg_rt_addr == src.reg2_write_reg_addr);

	// load still in REG2.
	assign do_hazard = src.reg2_do_dm_read && addr_match;
endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input  wire                            clk,
	input  wire                            arst_n,
	input  wire [pipe_pkg::reg_addr_w-1:0] ra_addr,
	input  wire [pipe_pkg::reg_addr_w-1:0] rb_addr,
	input  wire [pipe_pkg::reg_addr_w-1:0] rt_addr,
	output logic [pipe_pkg::data_w-1:0]    ra_data,
	output logic [pipe_pkg::data_w-1:0]    rb_data,
	output logic [pipe_pkg::data_w-1:0]    rt_data,
	input  wire                            wr_en,
	input  wire [pipe_pkg::reg_addr_w-1:0] wr_addr,
	input  wire [pipe_pkg::data_w-1:0]     wr_data
);
	logic [pipe_pkg::data_w-1:0] regs [0:(2**pipe_pkg::reg_addr_w)-1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2**pipe_pkg::reg_addr_w; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// no bypass here, REG4 forwarding covers the write cycle.
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];
endmodule

`default_nettype wire

//--- source/exec_alu.sv
`timescale 1ns/10ps
`default_nettype none

module exec_alu (
	input  var pipe_pkg::opcode_e       opcode,
	input  wire [pipe_pkg::data_w-1:0]  op_a,
	input  wire [pipe_pkg::data_w-1:0]  op_b,
	input  wire [pipe_pkg::data_w-1:0]  imm_extend,
	output logic [pipe_pkg::data_w-1:0] result
);
	always_comb begin
		case (opcode)
			pipe_pkg::op_add: begin
				result = op_a + op_b;
			end
			pipe_pkg::op_sub: begin
				result = op_a - op_b;
			end
			pipe_pkg::op_and: begin
				result = op_a & op_b;
			end
			pipe_pkg::op_or: begin
				result = op_a | op_b;
			end
			pipe_pkg::op_xor: begin
				result = op_a ^ op_b;
			end
			pipe_pkg::op_ld,
			pipe_pkg::op_st: begin
				// word address.
				result = op_a + imm_extend;
			end
			default: begin
				result = '0;
			end
		endcase
	end
endmodule

`default_nettype wire

//--- source/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem (
	input  wire                             clk,
	input  wire                             arst_n,
	input  wire [pipe_pkg::dmem_addr_w-1:0] addr,
	input  wire                             wr_en,
	input  wire [pipe_pkg::data_w-1:0]      wr_data,
	output logic [pipe_pkg::data_w-1:0]     rd_data
);
	logic [pipe_pkg::data_w-1:0] mem [0:(2**pipe_pkg::dmem_addr_w)-1];

	// cleared so loads of untouched words read zero.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2**pipe_pkg::dmem_addr_w; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[addr] <= wr_data;
		end
	end

	assign rd_data = mem[addr];
endmodule

`default_nettype wire

//--- source/mini_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module mini_pipe (
	input  wire                            clk,
	input  wire                            arst_n,
	input  wire                            instr_valid,
	input  wire [2:0]                      opcode,
	input  wire [pipe_pkg::reg_addr_w-1:0] ra,
	input  wire [pipe_pkg::reg_addr_w-1:0] rb,
	input  wire [pipe_pkg::reg_addr_w-1:0] rt,
	input  wire [pipe_pkg::imm_w-1:0]      imm,
	output logic                           stall,
	output logic                           wb_valid,
	output logic [pipe_pkg::reg_addr_w-1:0] wb_addr,
	output logic [pipe_pkg::data_w-1:0]    wb_data
);
	pipe_pkg::opcode_e               dec_opcode;
	pipe_pkg::wr_src_e               dec_select;
	logic [pipe_pkg::data_w-1:0]     dec_imm_extend;
	logic                            dec_load;
	logic                            dec_store;
	logic                            accept;
	logic                            do_hazard;
	logic [pipe_pkg::data_w-1:0]     rf_ra_data;
	logic [pipe_pkg::data_w-1:0]     rf_rb_data;
	logic [pipe_pkg::data_w-1:0]     rf_rt_data;
	logic [pipe_pkg::data_w-1:0]     f_ra_data;
	logic [pipe_pkg::data_w-1:0]     f_rb_data;
	logic [pipe_pkg::data_w-1:0]     f_rt_data;

	logic                            reg2_valid;
	logic                            reg2_is_load;
	logic                            reg2_is_store;
	pipe_pkg::opcode_e               reg2_opcode;
	pipe_pkg::wr_src_e               reg2_select;
	logic [pipe_pkg::reg_addr_w-1:0] reg2_write_reg_addr;
	logic [pipe_pkg::data_w-1:0]     reg2_imm_extend;
	logic [pipe_pkg::data_w-1:0]     reg2_ra_data;
	logic [pipe_pkg::data_w-1:0]     reg2_rb_data;
	logic [pipe_pkg::data_w-1:0]     reg2_rt_data;
	logic [pipe_pkg::data_w-1:0]     alu_result;

	logic                            reg3_valid;
	logic                            reg3_is_load;
	logic                            reg3_is_store;
	logic [pipe_pkg::reg_addr_w-1:0] reg3_write_reg_addr;
	logic [pipe_pkg::data_w-1:0]     reg3_result;
	logic [pipe_pkg::data_w-1:0]     reg3_rt_data;
	logic [pipe_pkg::data_w-1:0]     dm_rd_data;

	logic                            reg4_valid;
	logic                            reg4_do_reg_write;
	logic [pipe_pkg::reg_addr_w-1:0] reg4_write_reg_addr;
	logic [pipe_pkg::data_w-1:0]     reg4_write_reg_data;

	fwd_src_if src ();

	// stage 1 decode, rt is the destination.
	always_comb begin
		dec_opcode = pipe_pkg::opcode_e'(opcode);
		dec_load = (dec_opcode == pipe_pkg::op_ld);
		dec_store = (dec_opcode == pipe_pkg::op_st);
		case (dec_opcode)
			pipe_pkg::op_li: dec_select = pipe_pkg::wrreg_imm;
			pipe_pkg::op_ld: dec_select = pipe_pkg::wrreg_mem;
			default:         dec_select = pipe_pkg::wrreg_alu;
		endcase
	end

	assign dec_imm_extend = {{(pipe_pkg::data_w - pipe_pkg::imm_w){imm[pipe_pkg::imm_w-1]}}, imm};

	// hold the source, bubble into REG2.
	assign stall = instr_valid && do_hazard;
	assign accept = instr_valid && !stall;

	reg_file u_reg_file (
		.clk     (clk),
		.arst_n  (arst_n),
		.ra_addr (ra),
		.rb_addr (rb),
		.rt_addr (rt),
		.ra_data (rf_ra_data),
		.rb_data (rf_rb_data),
		.rt_data (rf_rt_data),
		.wr_en   (reg4_valid && reg4_do_reg_write),
		.wr_addr (reg4_write_reg_addr),
		.wr_data (reg4_write_reg_data)
	);

	forward_unit u_forward_unit (
		.reg_ra_addr   (ra),
		.reg_rb_addr   (rb),
		.reg_rt_addr   (rt),
		.reg_ra_data   (rf_ra_data),
		.reg_rb_data   (rf_rb_data),
		.reg_rt_data   (rf_rt_data),
		.src           (src),
		.f_reg_ra_data (f_ra_data),
		.f_reg_rb_data (f_rb_data),
		.f_reg_rt_data (f_rt_data),
		.do_hazard     (do_hazard)
	);

	exec_alu u_exec_alu (
		.opcode     (reg2_opcode),
		.op_a       (reg2_ra_data),
		.op_b       (reg2_rb_data),
		.imm_extend (reg2_imm_extend),
		.result     (alu_result)
	);

	data_mem u_data_mem (
		.clk     (clk),
		.arst_n  (arst_n),
		.addr    (reg3_result[pipe_pkg::dmem_addr_w-1:0]),
		.wr_en   (reg3_valid && reg3_is_store),
		.wr_data (reg3_rt_data),
		.rd_data (dm_rd_data)
	);

	assign src.reg2_do_dm_read = reg2_valid && reg2_is_load;
	assign src.reg2_do_reg_write = reg2_valid && !reg2_is_store;
	assign src.reg2_select_write_reg = reg2_select;
	assign src.reg2_write_reg_addr = reg2_write_reg_addr;
	assign src.reg2_imm_extend = reg2_imm_extend;
	assign src.alu_result = alu_result;
	assign src.reg3_do_reg_write = reg3_valid && !reg3_is_store;
	assign src.reg3_write_reg_addr = reg3_write_reg_addr;
	// loaded word or passed-through value.
	assign src.write_reg_data = reg3_is_load ? dm_rd_data : reg3_result;
	assign src.reg4_do_reg_write = reg4_valid && reg4_do_reg_write;
	assign src.reg4_write_reg_addr = reg4_write_reg_addr;
	assign src.reg4_write_reg_data = reg4_write_reg_data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reg2_valid <= 1'b0;
			reg2_is_load <= 1'b0;
			reg2_is_store <= 1'b0;
			reg3_valid <= 1'b0;
			reg3_is_load <= 1'b0;
			reg3_is_store <= 1'b0;
			reg4_valid <= 1'b0;
			reg4_do_reg_write <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			reg2_valid <= accept;
			reg2_is_load <= dec_load;
			reg2_is_store <= dec_store;
			reg3_valid <= reg2_valid;
			reg3_is_load <= reg2_is_load;
			reg3_is_store <= reg2_is_store;
			reg4_valid <= reg3_valid;
			reg4_do_reg_write <= !reg3_is_store;
			wb_valid <= src.reg4_do_reg_write;
		end
	end

	always_ff @(posedge clk) begin
		reg2_opcode <= dec_opcode;
		reg2_select <= dec_select;
		reg2_write_reg_addr <= rt;
		reg2_imm_extend <= dec_imm_extend;
		reg2_ra_data <= f_ra_data;
		reg2_rb_data <= f_rb_data;
		reg2_rt_data <= f_rt_data;
		reg3_write_reg_addr <= reg2_write_reg_addr;
		reg3_result <= (reg2_select == pipe_pkg::wrreg_imm) ? reg2_imm_extend : alu_result;
		reg3_rt_data <= reg2_rt_data;
		reg4_write_reg_addr <= reg3_write_reg_addr;
		reg4_write_reg_data <= src.write_reg_data;
		// registered at the register file write edge.
		wb_addr <= reg4_write_reg_addr;
		wb_data <= reg4_write_reg_data;
	end
endmodule

`default_nettype wire

//--- bench/pipe_model.svh
`ifndef PIPE_MODEL_SVH
`define PIPE_MODEL_SVH

// architectural state updated in program order.
logic [pipe_pkg::data_w-1:0] model_regs [0:(2**pipe_pkg::reg_addr_w)-1];
logic [pipe_pkg::data_w-1:0] model_mem [0:(2**pipe_pkg::dmem_addr_w)-1];

function automatic void model_clear();
	foreach (model_regs[i]) begin
		model_regs[i] = '0;
	end
	foreach (model_mem[i]) begin
		model_mem[i] = '0;
	end
endfunction

// runs one instruction and returns 1 when it writes rt.
function automatic logic model_exec(
	input  pipe_pkg::opcode_e               op,
	input  logic [pipe_pkg::reg_addr_w-1:0] src_a,
	input  logic [pipe_pkg::reg_addr_w-1:0] src_b,
	input  logic [pipe_pkg::reg_addr_w-1:0] dst,
	input  logic [pipe_pkg::imm_w-1:0]      value,
	output logic [pipe_pkg::reg_addr_w-1:0] wr_addr,
	output logic [pipe_pkg::data_w-1:0]     wr_data
);
	logic [pipe_pkg::data_w-1:0] a;
	logic [pipe_pkg::data_w-1:0] b;
	logic [pipe_pkg::data_w-1:0] sext;
	logic [pipe_pkg::data_w-1:0] ea;
	logic                        writes;
	a = model_regs[src_a];
	b = model_regs[src_b];
	sext = $signed(value);
	// word address wraps within the memory.
	ea = a + sext;
	writes = 1'b1;
	wr_addr = dst;
	wr_data = '0;
	case (op)
		pipe_pkg::op_add: wr_data = a + b;
		pipe_pkg::op_sub: wr_data = a - b;
		pipe_pkg::op_and: wr_data = a & b;
		pipe_pkg::op_or:  wr_data = a | b;
		pipe_pkg::op_xor: wr_data = a ^ b;
		pipe_pkg::op_li:  wr_data = sext;
		pipe_pkg::op_ld:  wr_data = model_mem[ea[pipe_pkg::dmem_addr_w-1:0]];
		default: begin
			// store takes its data from rt.
			model_mem[ea[pipe_pkg::dmem_addr_w-1:0]] = model_regs[dst];
			writes = 1'b0;
		end
	endcase
	if (writes) begin
		model_regs[dst] = wr_data;
	end
	return writes;
endfunction

`endif

//--- bench/mini_pipe_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mini_pipe_tb;
	typedef struct packed {
		logic [pipe_pkg::reg_addr_w-1:0] addr;
		logic [pipe_pkg::data_w-1:0]     data;
		logic [31:0]                     due;
	} wb_expect_t;

	// instructions per test: readback, chains, store/load, load-use, random.
	localparam int n_instr = 64 + 23 + 9 + 12 + 301;
	localparam int watchdog_cycles = n_instr * 4 + 200;

	logic                            clk = 1'b0;
	logic                            arst_n;
	logic                            instr_valid;
	logic [2:0]                      opcode;
	logic [pipe_pkg::reg_addr_w-1:0] ra;
	logic [pipe_pkg::reg_addr_w-1:0] rb;
	logic [pipe_pkg::reg_addr_w-1:0] rt;
	logic [pipe_pkg::imm_w-1:0]      imm;
	logic                            stall;
	logic                            wb_valid;
	logic [pipe_pkg::reg_addr_w-1:0] wb_addr;
	logic [pipe_pkg::data_w-1:0]     wb_data;

	wb_expect_t  exp_q[$];
	string       test_name = "reset";
	int unsigned cyc = 0;
	int          checks = 0;
	int          errors = 0;
	int          tests_run = 0;
	int          test_checks;
	int          test_errors;
	int          last_stalls;

	`include "pipe_model.svh"

	mini_pipe dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.opcode      (opcode),
		.ra          (ra),
		.rb          (rb),
		.rt          (rt),
		.imm         (imm),
		.stall       (stall),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// outputs are stable at the falling edge.
	always @(negedge clk) begin
		wb_expect_t want;
		if (arst_n && wb_valid) begin
			checks++;
			assert (exp_q.size() > 0) else begin
				$display("%s: write-back to r%0d with no instruction pending", test_name, wb_addr);
				errors++;
			end
			if (exp_q.size() > 0) begin
				want = exp_q.pop_front();
				assert (wb_addr == want.addr && wb_data == want.data) else begin
					$display("FAIL %s: expected r%0d=%08h actual r%0d=%08h",
						test_name, want.addr, want.data, wb_addr, wb_data);
					errors++;
				end
				assert (cyc == want.due) else begin
					$display("FAIL %s: write-back cycle expected %0d actual %0d",
						test_name, want.due, cyc);
					errors++;
				end
			end
		end
	end

	task automatic issue_instr(input pipe_pkg::opcode_e op,
			input logic [pipe_pkg::reg_addr_w-1:0] src_a,
			input logic [pipe_pkg::reg_addr_w-1:0] src_b,
			input logic [pipe_pkg::reg_addr_w-1:0] dst,
			input logic [pipe_pkg::imm_w-1:0] value);
		logic [pipe_pkg::reg_addr_w-1:0] want_addr;
		logic [pipe_pkg::data_w-1:0]     want_data;
		wb_expect_t                      entry;
		last_stalls = 0;
		@(negedge clk);
		instr_valid = 1'b1;
		opcode = op;
		ra = src_a;
		rb = src_b;
		rt = dst;
		imm = value;
		#1;
		// held while stalled, taken at the next rising edge.
		while (stall) begin
			last_stalls++;
			@(negedge clk);
			#1;
		end
		if (model_exec(op, src_a, src_b, dst, value, want_addr, want_data)) begin
			entry.addr = want_addr;
			entry.data = want_data;
			entry.due = cyc + 4;
			exp_q.push_back(entry);
		end
	endtask

	task automatic load_imm(input logic [4:0] dst, input logic [15:0] value);
		issue_instr(pipe_pkg::op_li, 5'd0, 5'd0, dst, value);
	endtask

	task automatic alu_op(input pipe_pkg::opcode_e op, input logic [4:0] dst,
			input logic [4:0] src_a, input logic [4:0] src_b);
		issue_instr(op, src_a, src_b, dst, 16'h0000);
	endtask

	task automatic load_word(input logic [4:0] dst, input logic [4:0] base,
			input logic [15:0] offset);
		issue_instr(pipe_pkg::op_ld, base, 5'd0, dst, offset);
	endtask

	task automatic store_word(input logic [4:0] data_reg, input logic [4:0] base,
			input logic [15:0] offset);
		issue_instr(pipe_pkg::op_st, base, 5'd0, data_reg, offset);
	endtask

	task automatic check_stalls(input int expected);
		checks++;
		assert (last_stalls == expected) else begin
			$display("FAIL %s: stall cycles expected %0d actual %0d",
				test_name, expected, last_stalls);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic finish_test();
		int waited;
		waited = 0;
		@(negedge clk);
		instr_valid = 1'b0;
		while (exp_q.size() > 0 && waited < 10) begin
			@(negedge clk);
			waited++;
		end
		// idle cycles catch stray write-backs.
		repeat (3) @(negedge clk);
		checks++;
		assert (exp_q.size() == 0) else begin
			$display("%s: %0d expected write-backs never arrived", test_name, exp_q.size());
			errors++;
			exp_q.delete();
		end
		tests_run++;
		$display("%s: %0d checks, %0d errors", test_name,
			checks - test_checks, errors - test_errors);
	endtask

	task automatic readback_regs();
		start_test("li_readback");
		for (int r = 0; r < 32; r++) begin
			load_imm(5'(r), 16'($urandom()));
		end
		for (int r = 0; r < 32; r++) begin
			alu_op(pipe_pkg::op_or, 5'(r), 5'(r), 5'(r));
		end
		finish_test();
	endtask

	task automatic forward_chains();
		start_test("fwd_chain");
		// producer at distance 1 to 4 from its user.
		for (int d = 1; d <= 4; d++) begin
			load_imm(5'd20, 16'($urandom()));
			for (int k = 1; k < d; k++) begin
				load_imm(5'(20 + k), 16'($urandom()));
			end
			alu_op(pipe_pkg::op_add, 5'd25, 5'd20, 5'd20);
		end
		// same register written three times in a row.
		load_imm(5'd6, 16'h0001);
		load_imm(5'd6, 16'h0002);
		load_imm(5'd6, 16'h0003);
		alu_op(pipe_pkg::op_add, 5'd7, 5'd6, 5'd6);
		alu_op(pipe_pkg::op_and, 5'd8, 5'd6, 5'd7);
		load_imm(5'd9, 16'h8001);
		alu_op(pipe_pkg::op_add, 5'd9, 5'd9, 5'd9);
		alu_op(pipe_pkg::op_sub, 5'd9, 5'd9, 5'd6);
		alu_op(pipe_pkg::op_xor, 5'd10, 5'd9, 5'd7);
		finish_test();
	endtask

	task automatic store_then_load();
		start_test("store_load");
		load_imm(5'd1, 16'h0010);
		load_imm(5'd2, 16'($urandom()));
		// store data produced one instruction earlier.
		store_word(5'd2, 5'd1, 16'd3);
		load_word(5'd3, 5'd1, 16'd3);
		load_imm(5'd4, 16'h0012);
		load_word(5'd5, 5'd4, 16'd1);
		load_imm(5'd6, 16'($urandom()));
		store_word(5'd6, 5'd4, 16'hfffe);
		load_word(5'd7, 5'd1, 16'd0);
		finish_test();
	endtask

	task automatic load_use_stall();
		start_test("load_use");
		load_imm(5'd10, 16'h0020);
		load_imm(5'd11, 16'($urandom()));
		store_word(5'd11, 5'd10, 16'd0);
		load_imm(5'd12, 16'h0000);
		load_word(5'd13, 5'd10, 16'd0);
		alu_op(pipe_pkg::op_add, 5'd14, 5'd13, 5'd10);
		check_stalls(1);
		load_word(5'd15, 5'd10, 16'd0);
		store_word(5'd15, 5'd10, 16'd1);
		check_stalls(1);
		load_word(5'd16, 5'd10, 16'd1);
		alu_op(pipe_pkg::op_or, 5'd17, 5'd11, 5'd16);
		check_stalls(1);
		// independent instruction after a load.
		load_word(5'd18, 5'd10, 16'd0);
		load_imm(5'd19, 16'h1234);
		check_stalls(0);
		finish_test();
	endtask

	task automatic random_mix();
		pipe_pkg::opcode_e op;
		start_test("random_mix");
		// r31 as a zero base keeps addresses in 0..7.
		load_imm(5'd31, 16'h0000);
		for (int i = 0; i < 300; i++) begin
			op = pipe_pkg::opcode_e'(3'($urandom_range(7, 0)));
			if (op == pipe_pkg::op_ld || op == pipe_pkg::op_st) begin
				issue_instr(op, 5'd31, 5'($urandom_range(7, 0)),
					5'($urandom_range(7, 0)), 16'($urandom_range(7, 0)));
			end else begin
				issue_instr(op, 5'($urandom_range(7, 0)), 5'($urandom_range(7, 0)),
					5'($urandom_range(7, 0)), 16'($urandom()));
			end
		end
		finish_test();
	endtask

	initial begin
		arst_n = 1'b0;
		instr_valid = 1'b0;
		opcode = '0;
		ra = '0;
		rb = '0;
		rt = '0;
		imm = '0;
		void'($urandom(49899));
		model_clear();
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		checks++;
		assert (!wb_valid && !stall) else begin
			$display("outputs not idle after reset");
			errors++;
		end
		readback_regs();
		forward_chains();
		store_then_load();
		load_use_stall();
		random_mix();
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * 10);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("Simulation failed");
		$finish;
	end
endmodule

`default_nettype wire

//--- filelist.f
+incdir+bench
source/pipe_pkg.sv
source/fwd_src_if.sv
source/operand_forward.sv
source/forward_unit.sv
source/reg_file.sv
source/exec_alu.sv
source/data_mem.sv
source/mini_pipe.sv
bench/mini_pipe_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the mini_pipe testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mini_pipe_tb \
	-f filelist.f -Mdir obj_dir -o sim_mini_pipe \
	&& sim_out="$(./obj_dir/sim_mini_pipe)" \
	&& printf '%s\n' "$sim_out" \
	&& printf '%s\n' "$sim_out" | grep -qx "Simulation completed successfully" \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }
